// File: dcache.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_store.sv
hw/dcache_lookup.sv
hw/dcache_miss_unit.sv
hw/dcache_top.sv
verification/dcache_properties.sv
verification/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - hw
    files:
      - hw/dcache_pkg.sv
      - hw/dcache_store.sv
      - hw/dcache_lookup.sv
      - hw/dcache_miss_unit.sv
      - hw/dcache_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/dcache_properties.sv
      - verification/dcache_tb.sv

// File: verification/dcache_tb.sv
`include "dcache_macros.svh"

module dcache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS   = 17;
    localparam int MAX_CYCLES = NUM_ROWS * 40;

    typedef struct {
        dcache_pkg::cpu_op_e           op;
        dcache_pkg::addr_t             addr;
        dcache_pkg::word_t             wdata;
        logic [dcache_pkg::BE_W-1:0]   be;
        logic                          stall;
        dcache_pkg::word_t             exp;
    } row_t;

    logic                 clk;
    logic                 rst;
    dcache_pkg::cpu_req_t req;
    logic                 req_valid;
    logic                 req_ready;
    dcache_pkg::word_t    resp_rdata;
    logic                 resp_valid;
    logic                 resp_ready;
    dcache_pkg::mem_req_t mem_req;
    logic                 mem_req_valid;
    logic                 mem_req_ready;
    logic                 mem_rvalid;
    dcache_pkg::word_t    mem_rdata;

    row_t              rows [NUM_ROWS];
    dcache_pkg::word_t model_mem [dcache_pkg::addr_t];
    dcache_pkg::word_t mem_words [dcache_pkg::addr_t];
    integer            seed = 75800;
    int                cycles;
    int                err_count;
    int                cur_row;
    int                wb_beat;
    int                rd_beat;
    int                wb_total;
    int                wb_rows;
    logic              wb_due     [NUM_ROWS];
    logic [23:0]       victim_tag [NUM_ROWS];

    dcache_top uut (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .resp_rdata    (resp_rdata),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rvalid    (mem_rvalid),
        .mem_rdata     (mem_rdata)
    );

    bind dcache_top dcache_properties u_props (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .resp_rdata    (resp_rdata),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rvalid    (mem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        err_count++;
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_w,
                                                      input dcache_pkg::word_t new_w,
                                                      input logic [3:0] be);
        dcache_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // Untouched words read back as their inverted word address
    function automatic dcache_pkg::word_t model_read(input dcache_pkg::addr_t addr);
        dcache_pkg::addr_t key;
        key = {addr[31:2], 2'b00};
        return model_mem.exists(key) ? model_mem[key] : ~key;
    endfunction

    function automatic void model_write(input row_t r);
        model_mem[{r.addr[31:2], 2'b00}] = merge_bytes(model_read(r.addr), r.wdata, r.be);
    endfunction

    function automatic dcache_pkg::word_t mem_read(input dcache_pkg::addr_t addr);
        return mem_words.exists(addr) ? mem_words[addr] : ~addr;
    endfunction

    task automatic load_table();
        // op, address, write data, byte enables, stall response, expected
        rows[0]  = '{dcache_pkg::OP_READ,  32'h0000_0100, 32'h0, 4'b0000, 1'b0, 32'h0};
        rows[1]  = '{dcache_pkg::OP_READ,  32'h0000_0104, 32'h0, 4'b0000, 1'b0, 32'h0};
        rows[2]  = '{dcache_pkg::OP_WRITE, 32'h0000_0108, 32'hA5A5_1234, 4'b0101, 1'b0, 32'h0};
        rows[3]  = '{dcache_pkg::OP_READ,  32'h0000_0108, 32'h0, 4'b0000, 1'b0, 32'h0};
        rows[4]  = '{dcache_pkg::OP_READ,  32'h0000_010C, 32'h0, 4'b0000, 1'b1, 32'h0};
        // Same set, other tag, evicts the dirty line
        rows[5]  = '{dcache_pkg::OP_READ,  32'h0000_0200, 32'h0, 4'b0000, 1'b0, 32'h0};
        rows[6]  = '{dcache_pkg::OP_READ,  32'h0000_0108, 32'h0, 4'b0000, 1'b1, 32'h0};
        rows[7]  = '{dcache_pkg::OP_WRITE, 32'h0000_0214, 32'hDEAD_BEEF, 4'b1100, 1'b0, 32'h0};
        rows[8]  = '{dcache_pkg::OP_READ,  32'h0000_0214, 32'h0, 4'b0000, 1'b0, 32'h0};
        rows[9]  = '{dcache_pkg::OP_READ,  32'h0001_0210, 32'h0, 4'b0000, 1'b0, 32'h0};
        rows[10] = '{dcache_pkg::OP_READ,  32'h0000_0214, 32'h0, 4'b0000, 1'b0, 32'h0};
        rows[11] = '{dcache_pkg::OP_WRITE, 32'hFFFF_FFF0, 32'h1357_9BDF, 4'b1000, 1'b1, 32'h0};
        rows[12] = '{dcache_pkg::OP_READ,  32'hFFFF_FFF4, 32'h0, 4'b0000, 1'b0, 32'h0};
        rows[13] = '{dcache_pkg::OP_READ,  32'h0000_00F0, 32'h0, 4'b0000, 1'b0, 32'h0};
        rows[14] = '{dcache_pkg::OP_READ,  32'hFFFF_FFF0, 32'h0, 4'b0000, 1'b0, 32'h0};
        rows[15] = '{dcache_pkg::OP_WRITE, 32'h0000_0104, 32'h0BAD_F00D, 4'b0010, 1'b0, 32'h0};
        rows[16] = '{dcache_pkg::OP_READ,  32'h0000_0104, 32'h0, 4'b0000, 1'b0, 32'h0};
    endtask

    // Every response is the word as it stood before the request
    task automatic compute_expected();
        logic [23:0] line_tag   [`DCACHE_SETS];
        logic        line_valid [`DCACHE_SETS];
        logic        line_dirty [`DCACHE_SETS];
        logic        line_hit;
        int          idx;
        for (int s = 0; s < `DCACHE_SETS; s++) begin
            line_tag[s]   = '0;
            line_valid[s] = 1'b0;
            line_dirty[s] = 1'b0;
        end
        wb_rows = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            rows[i].exp = model_read(rows[i].addr);
            if (rows[i].op == dcache_pkg::OP_WRITE) begin
                model_write(rows[i]);
            end
            // A miss on a dirty line writes the old line back first
            idx           = rows[i].addr[7:4];
            line_hit      = line_valid[idx] && (line_tag[idx] == rows[i].addr[31:8]);
            wb_due[i]     = line_valid[idx] && line_dirty[idx] && !line_hit;
            victim_tag[i] = line_tag[idx];
            if (wb_due[i]) begin
                wb_rows++;
            end
            line_dirty[idx] = (line_hit && line_dirty[idx]) ||
                              (rows[i].op == dcache_pkg::OP_WRITE);
            line_valid[idx] = 1'b1;
            line_tag[idx]   = rows[i].addr[31:8];
        end
        model_mem.delete();
    endtask

    task automatic issue_rows();
        for (int i = 0; i < NUM_ROWS; i++) begin
            req.op    = rows[i].op;
            req.addr  = rows[i].addr;
            req.wdata = rows[i].wdata;
            req.be    = rows[i].be;
            req_valid = 1'b1;
            @(negedge clk);
            while (!req_ready) @(negedge clk);
            @(posedge clk);
            #2;
        end
        req_valid = 1'b0;
    endtask

    task automatic collect_responses();
        dcache_pkg::word_t held;
        for (int k = 0; k < NUM_ROWS; k++) begin
            cur_row    = k;
            resp_ready = !rows[k].stall;
            @(negedge clk);
            while (!resp_valid) @(negedge clk);
            if (rows[k].stall) begin
                held = resp_rdata;
                repeat (3) begin
                    @(negedge clk);
                    assert (resp_valid)
                        else fail_now("response withdrawn while resp_ready was held low");
                    assert (resp_rdata === held)
                        else fail_now($sformatf("ERR t=%0t resp_rdata expected %h actual %h",
                                                $time, held, resp_rdata));
                end
                @(posedge clk);
                #2;
                resp_ready = 1'b1;
                @(negedge clk);
            end
            assert (resp_rdata === rows[k].exp)
                else fail_now($sformatf("ERR t=%0t resp_rdata expected %h actual %h",
                                        $time, rows[k].exp, resp_rdata));
            if (rows[k].op == dcache_pkg::OP_WRITE) begin
                model_write(rows[k]);
            end
            @(posedge clk);
            #2;
        end
        resp_ready = 1'b1;
    endtask

    // Victim words in ascending order, holding the latest CPU data
    task automatic check_write_beat(input dcache_pkg::mem_req_t beat);
        dcache_pkg::addr_t exp_addr;
        assert (wb_due[cur_row])
            else fail_now($sformatf("write-back at t=%0t while row %0d evicts no dirty line",
                                    $time, cur_row));
        exp_addr = {victim_tag[cur_row], rows[cur_row].addr[7:4], 2'(wb_beat), 2'b00};
        assert (beat.addr === exp_addr)
            else fail_now($sformatf("ERR t=%0t mem_req.addr expected %h actual %h",
                                    $time, exp_addr, beat.addr));
        assert (beat.wdata === model_read(beat.addr))
            else fail_now($sformatf("ERR t=%0t mem_req.wdata expected %h actual %h",
                                    $time, model_read(beat.addr), beat.wdata));
        wb_beat = (wb_beat + 1) % `DCACHE_LINE_WORDS;
        wb_total++;
    endtask

    task automatic check_read_beat(input dcache_pkg::addr_t addr);
        dcache_pkg::addr_t exp_addr;
        exp_addr = {rows[cur_row].addr[31:4], 2'(rd_beat), 2'b00};
        assert (addr === exp_addr)
            else fail_now($sformatf("ERR t=%0t mem_req.addr expected %h actual %h",
                                    $time, exp_addr, addr));
        rd_beat = (rd_beat + 1) % `DCACHE_LINE_WORDS;
    endtask

    initial begin : memory_model
        dcache_pkg::mem_req_t beat;
        dcache_pkg::addr_t    rd_addr;
        logic                 taken;
        logic                 rd_pending;
        int                   rd_wait;
        rd_pending = 1'b0;
        rd_wait    = 0;
        rd_addr    = '0;
        forever begin
            @(negedge clk);
            taken = mem_req_valid && mem_req_ready;
            beat  = mem_req;
            @(posedge clk);
            #2;
            mem_rvalid = 1'b0;
            if (taken && beat.we) begin
                check_write_beat(beat);
                mem_words[beat.addr] = beat.wdata;
            end else if (taken) begin
                assert (!rd_pending)
                    else fail_now("memory read issued while another read was outstanding");
                check_read_beat(beat.addr);
                rd_pending = 1'b1;
                rd_addr    = beat.addr;
                rd_wait    = $unsigned($random(seed)) % 3;
            end
            // Data strobe lands 1 to 3 cycles after the read is taken
            if (rd_pending) begin
                if (rd_wait == 0) begin
                    mem_rvalid = 1'b1;
                    mem_rdata  = mem_read(rd_addr);
                    rd_pending = 1'b0;
                end else begin
                    rd_wait--;
                end
            end
            mem_req_ready = ($random(seed) & 3) != 0;
        end
    end

    initial begin : cycle_limit
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            assert (cycles <= MAX_CYCLES)
                else fail_now($sformatf("timeout, run did not finish in %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        rst           = 1'b1;
        req           = '0;
        req_valid     = 1'b0;
        resp_ready    = 1'b0;
        mem_req_ready = 1'b0;
        mem_rvalid    = 1'b0;
        mem_rdata     = '0;
        err_count     = 0;
        cur_row       = 0;
        wb_beat       = 0;
        rd_beat       = 0;
        wb_total      = 0;
        load_table();
        compute_expected();
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        fork
            issue_rows();
            collect_responses();
        join
        assert (wb_total == wb_rows * `DCACHE_LINE_WORDS)
            else fail_now($sformatf("ERR t=%0t write-back beats expected %0d actual %0d",
                                    $time, wb_rows * `DCACHE_LINE_WORDS, wb_total));
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verification/dcache_properties.sv
module dcache_properties (
    input logic                 clk,
    input logic                 rst,
    input dcache_pkg::cpu_req_t req,
    input logic                 req_valid,
    input logic                 req_ready,
    input dcache_pkg::word_t    resp_rdata,
    input logic                 resp_valid,
    input logic                 resp_ready,
    input dcache_pkg::mem_req_t mem_req,
    input logic                 mem_req_valid,
    input logic                 mem_req_ready,
    input logic                 mem_rvalid
);

    timeunit 1ns;
    timeprecision 100ps;

    // Set by an accepted memory read, cleared by its data strobe
    logic rd_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_out <= 1'b0;
        end else if (mem_req_valid && mem_req_ready && !mem_req.we) begin
            rd_out <= 1'b1;
        end else if (mem_rvalid) begin
            rd_out <= 1'b0;
        end
    end

    req_stable: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("CPU request changed before it was accepted");

    resp_held: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
        else $error("response dropped or changed before it was accepted");

    mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("memory request changed before it was accepted");

    one_read: assert property (@(posedge clk) disable iff (rst)
        rd_out |-> !mem_req_valid)
        else $error("memory request issued while a read is outstanding");

endmodule

// File: hw/dcache_top.sv
`include "dcache_macros.svh"

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::cpu_req_t req,
    input  logic                 req_valid,
    output logic                 req_ready,
    output dcache_pkg::word_t    resp_rdata,
    output logic                 resp_valid,
    input  logic                 resp_ready,
    output dcache_pkg::mem_req_t mem_req,
    output logic                 mem_req_valid,
    input  logic                 mem_req_ready,
    input  logic                 mem_rvalid,
    input  dcache_pkg::word_t    mem_rdata
);

    logic                   rd_en;
    dcache_pkg::index_t     rd_index;
    dcache_pkg::tag_entry_t rd_tag;
    dcache_pkg::line_t      rd_line;
    dcache_pkg::store_wr_t  store_wr;
    dcache_pkg::miss_req_t  miss;
    logic                   miss_valid;
    logic                   fill_valid;
    dcache_pkg::line_t      fill_line;

    // Stage 1 reads the arrays as a request is accepted
    assign rd_en    = req_valid && req_ready;
    assign rd_index = dcache_pkg::addr_index(req.addr);

    dcache_store u_store (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .wr       (store_wr),
        .rd_tag   (rd_tag),
        .rd_line  (rd_line)
    );

    dcache_lookup u_lookup (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .rd_tag     (rd_tag),
        .rd_line    (rd_line),
        .store_wr   (store_wr),
        .resp_rdata (resp_rdata),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .miss       (miss),
        .miss_valid (miss_valid),
        .fill_valid (fill_valid),
        .fill_line  (fill_line)
    );

    dcache_miss_unit u_miss_unit (
        .clk           (clk),
        .rst           (rst),
        .miss          (miss),
        .miss_valid    (miss_valid),
        .fill_valid    (fill_valid),
        .fill_line     (fill_line),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rvalid    (mem_rvalid),
        .mem_rdata     (mem_rdata)
    );

endmodule

// File: hw/dcache_miss_unit.sv
`include "dcache_macros.svh"

module dcache_miss_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::miss_req_t miss,
    input  logic                  miss_valid,
    output logic                  fill_valid,
    output dcache_pkg::line_t     fill_line,
    output dcache_pkg::mem_req_t  mem_req,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    input  logic                  mem_rvalid,
    input  dcache_pkg::word_t     mem_rdata
);

    dcache_pkg::miss_state_e state;
    dcache_pkg::miss_state_e state_next;

    dcache_pkg::miss_req_t miss_q;
    dcache_pkg::line_t     line_buf;
    // Word within the line, shared by write-back and refill
    dcache_pkg::offset_t   beat;
    logic                  last_beat;
    logic                  beat_done;
    dcache_pkg::tag_t      beat_tag;

    assign last_beat = (beat == dcache_pkg::offset_t'(`DCACHE_LINE_WORDS - 1));

    assign beat_done = ((state == dcache_pkg::MISS_WB) && mem_req_ready) ||
                       ((state == dcache_pkg::MISS_RD_WAIT) && mem_rvalid);

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::MISS_IDLE: begin
                if (miss_valid) begin
                    if (miss.victim.valid && miss.victim.dirty) begin
                        state_next = dcache_pkg::MISS_WB;
                    end else begin
                        state_next = dcache_pkg::MISS_RD_REQ;
                    end
                end
            end
            dcache_pkg::MISS_WB: begin
                if (mem_req_ready && last_beat) begin
                    state_next = dcache_pkg::MISS_RD_REQ;
                end
            end
            dcache_pkg::MISS_RD_REQ: begin
                if (mem_req_ready) begin
                    state_next = dcache_pkg::MISS_RD_WAIT;
                end
            end
            dcache_pkg::MISS_RD_WAIT: begin
                if (mem_rvalid) begin
                    state_next = last_beat ? dcache_pkg::MISS_FILL : dcache_pkg::MISS_RD_REQ;
                end
            end
            dcache_pkg::MISS_FILL: begin
                state_next = dcache_pkg::MISS_IDLE;
            end
            default: begin
                state_next = dcache_pkg::MISS_IDLE;
            end
        endcase
    end

    // Counter wraps after the last write beat, ready for the refill
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::MISS_IDLE;
            beat  <= '0;
        end else begin
            state <= state_next;
            if (state == dcache_pkg::MISS_IDLE) begin
                beat <= '0;
            end else if (beat_done) begin
                beat <= beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == dcache_pkg::MISS_IDLE) && miss_valid) begin
            miss_q <= miss;
        end
        if ((state == dcache_pkg::MISS_RD_WAIT) && mem_rvalid) begin
            line_buf[beat] <= mem_rdata;
        end
    end

    // Victim tag while writing back, missed tag while refilling
    assign beat_tag = (state == dcache_pkg::MISS_WB) ? miss_q.victim.tag : miss_q.tag;

    always_comb begin
        mem_req_valid = (state == dcache_pkg::MISS_WB) || (state == dcache_pkg::MISS_RD_REQ);
        mem_req.we    = (state == dcache_pkg::MISS_WB);
        mem_req.addr  = {beat_tag, miss_q.index, beat, {dcache_pkg::BYTE_OFF_W{1'b0}}};
        mem_req.wdata = miss_q.line[beat];
    end

    assign fill_valid = (state == dcache_pkg::MISS_FILL);
    assign fill_line  = line_buf;

endmodule

// File: hw/dcache_lookup.sv
`include "dcache_macros.svh"

module dcache_lookup (
    input  logic                   clk,
    input  logic                   rst,
    input  dcache_pkg::cpu_req_t   req,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  dcache_pkg::tag_entry_t rd_tag,
    input  dcache_pkg::line_t      rd_line,
    output dcache_pkg::store_wr_t  store_wr,
    output dcache_pkg::word_t      resp_rdata,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output dcache_pkg::miss_req_t  miss,
    output logic                   miss_valid,
    input  logic                   fill_valid,
    input  dcache_pkg::line_t      fill_line
);

    function automatic dcache_pkg::word_t merge_word(
        input dcache_pkg::word_t          old_word,
        input dcache_pkg::word_t          new_word,
        input logic [dcache_pkg::BE_W-1:0] be
    );
        dcache_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < `DCACHE_WORD_W / 8; b++) begin
            if (be[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    dcache_pkg::cpu_req_t s2_req;
    logic                 s2_valid;
    // Miss handed off, waiting for the refill
    logic                 s2_miss;
    // Refill written, response comes from fill_word
    logic                 s2_filled;
    dcache_pkg::word_t    fill_word;

    dcache_pkg::index_t  s2_index;
    dcache_pkg::offset_t s2_offset;
    dcache_pkg::tag_t    s2_tag;
    logic                is_write;
    logic                tag_match;
    logic                hit;
    logic                hand_off;
    logic                accept;
    dcache_pkg::line_t   src_line;
    dcache_pkg::line_t   merged_line;

    assign s2_index  = dcache_pkg::addr_index(s2_req.addr);
    assign s2_offset = dcache_pkg::addr_offset(s2_req.addr);
    assign s2_tag    = dcache_pkg::addr_tag(s2_req.addr);
    assign is_write  = (s2_req.op == dcache_pkg::OP_WRITE);

    // Store outputs line up with s2_req one cycle after acceptance
    assign tag_match  = rd_tag.valid && (rd_tag.tag == s2_tag);
    assign hit        = s2_valid && !s2_miss && tag_match;
    assign miss_valid = s2_valid && !s2_miss && !tag_match;

    assign resp_valid = hit || (s2_valid && s2_filled);
    assign hand_off   = resp_valid && resp_ready;
    assign req_ready  = !s2_valid || hand_off;
    assign accept     = req_valid && req_ready;

    // Old word, before any merge
    assign resp_rdata = s2_filled ? fill_word : rd_line[s2_offset];

    assign src_line = fill_valid ? fill_line : rd_line;

    always_comb begin
        merged_line = src_line;
        if (is_write) begin
            merged_line[s2_offset] = merge_word(src_line[s2_offset], s2_req.wdata, s2_req.be);
        end
    end

    // Write hits are committed on hand-off so held data stays stable
    always_comb begin
        store_wr.we          = fill_valid || (hit && is_write && resp_ready);
        store_wr.index       = s2_index;
        store_wr.entry.valid = 1'b1;
        store_wr.entry.dirty = is_write;
        store_wr.entry.tag   = s2_tag;
        store_wr.line        = merged_line;
    end

    always_comb begin
        miss.victim = rd_tag;
        miss.line   = rd_line;
        miss.index  = s2_index;
        miss.tag    = s2_tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid  <= 1'b0;
            s2_miss   <= 1'b0;
            s2_filled <= 1'b0;
        end else begin
            if (accept) begin
                s2_valid <= 1'b1;
            end else if (hand_off) begin
                s2_valid <= 1'b0;
            end
            if (hand_off) begin
                s2_miss   <= 1'b0;
                s2_filled <= 1'b0;
            end else begin
                if (miss_valid) begin
                    s2_miss <= 1'b1;
                end
                if (fill_valid) begin
                    s2_filled <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s2_req <= req;
        end
        if (fill_valid) begin
            fill_word <= fill_line[s2_offset];
        end
    end

endmodule

// File: hw/dcache_store.sv
`include "dcache_macros.svh"

module dcache_store (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_en,
    input  dcache_pkg::index_t     rd_index,
    input  dcache_pkg::store_wr_t  wr,
    output dcache_pkg::tag_entry_t rd_tag,
    output dcache_pkg::line_t      rd_line
);

    // Valid bits live in flops so reset can clear all of them at once
    logic [`DCACHE_SETS-1:0] valid_q;

    logic               dirty_mem [`DCACHE_SETS];
    dcache_pkg::tag_t   tag_mem   [`DCACHE_SETS];
    dcache_pkg::line_t  line_mem  [`DCACHE_SETS];

    logic bypass;

    // Same-cycle write to the set being read
    assign bypass = wr.we && (wr.index == rd_index);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr.we) begin
            valid_q[wr.index] <= wr.entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we) begin
            dirty_mem[wr.index] <= wr.entry.dirty;
            tag_mem[wr.index]   <= wr.entry.tag;
            line_mem[wr.index]  <= wr.line;
        end
    end

    // Synchronous read, outputs hold while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (bypass) begin
                rd_tag  <= wr.entry;
                rd_line <= wr.line;
            end else begin
                rd_tag.valid <= valid_q[rd_index];
                rd_tag.dirty <= dirty_mem[rd_index];
                rd_tag.tag   <= tag_mem[rd_index];
                rd_line      <= line_mem[rd_index];
            end
        end
    end

endmodule

// File: hw/dcache_pkg.sv
`include "dcache_macros.svh"

package dcache_pkg;

    // Derived address field widths
    localparam int BYTE_OFF_W = $clog2(`DCACHE_WORD_W / 8);
    localparam int OFFSET_W   = $clog2(`DCACHE_LINE_WORDS);
    localparam int INDEX_W    = $clog2(`DCACHE_SETS);
    localparam int TAG_W      = `DCACHE_ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;
    localparam int BE_W       = `DCACHE_WORD_W / 8;

    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
    typedef logic [`DCACHE_WORD_W-1:0] word_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [OFFSET_W-1:0]       offset_t;
    typedef logic [TAG_W-1:0]          tag_t;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cpu_op_e;

    typedef struct packed {
        cpu_op_e           op;
        addr_t             addr;
        word_t             wdata;
        logic [BE_W-1:0]   be;
    } cpu_req_t;

    // One memory beat, address is word aligned
    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef logic [`DCACHE_LINE_WORDS-1:0][`DCACHE_WORD_W-1:0] line_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // Everything the miss unit needs to evict and refill one set
    typedef struct packed {
        tag_entry_t victim;
        line_t      line;
        index_t     index;
        tag_t       tag;
    } miss_req_t;

    typedef enum logic [2:0] {
        MISS_IDLE,
        MISS_WB,
        MISS_RD_REQ,
        MISS_RD_WAIT,
        MISS_FILL
    } miss_state_e;

    typedef struct packed {
        logic       we;
        index_t     index;
        tag_entry_t entry;
        line_t      line;
    } store_wr_t;

    function automatic index_t addr_index(input addr_t addr);
        return addr[BYTE_OFF_W + OFFSET_W +: INDEX_W];
    endfunction

    function automatic tag_t addr_tag(input addr_t addr);
        return addr[`DCACHE_ADDR_W-1 -: TAG_W];
    endfunction

    function automatic offset_t addr_offset(input addr_t addr);
        return addr[BYTE_OFF_W +: OFFSET_W];
    endfunction

endpackage

// File: hw/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Cache geometry shared by the RTL and the testbench

// Byte address width on both the CPU and memory ports
`define DCACHE_ADDR_W 32

// Data word width, also the memory beat width
`define DCACHE_WORD_W 32

// Number of lines in the direct-mapped array
`define DCACHE_SETS 16

// Words per line, one memory beat each
`define DCACHE_LINE_WORDS 4

`endif
